// ==== Bender.yml ====
package:
  name: rv32i_core

sources:
  - hw/rv_pkg.sv
  - hw/fetch_unit.sv
  - hw/reg_bank.sv
  - hw/decode_stage.sv
  - hw/execute_stage.sv
  - hw/rv32i_core.sv
  - target: simulation
    files:
      - sim/core_checker.sv
      - sim/core_tb.sv

// ==== hw/decode_stage.sv ====
module decode_stage (
  input  logic                    clk,
  input  logic                    rst,
  input  rv_pkg::fetch_t          fetch_in,
  input  logic                    flush,
  input  rv_pkg::retire_t         wb,
  output rv_pkg::decoded_t        dec_out,
  output logic [rv_pkg::xlen-1:0] rs1_data,
  output logic [rv_pkg::xlen-1:0] rs2_data
);
  import rv_pkg::*;

  logic [xlen-1:0] instr;
  logic [2:0]      funct3;
  opcode_e         opc;
  alu_op_e         alu_sel;
  alu_op_e         br_sel;
  logic            br_ok;
  logic [xlen-1:0] imm_i, imm_u, imm_b, imm_j;
  logic [xlen-1:0] bank_rs1, bank_rs2;
  decoded_t        dec_d, dec_q;
  logic            dec_valid;

  assign instr  = fetch_in.instr;
  assign funct3 = instr[14:12];

  // b and j use the encoded offset field as a word count
  assign imm_i = {{20{instr[31]}}, instr[31:20]};
  assign imm_u = {instr[31:12], 12'b0};
  assign imm_b = {{21{instr[31]}}, instr[7], instr[30:25], instr[11:8]};
  assign imm_j = {{12{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21]};

  reg_bank u_regs (
    .clk      (clk),
    .rst      (rst),
    .rs1      (instr[19:15]),
    .rs2      (instr[24:20]),
    .wb       (wb),
    .rs1_data (bank_rs1),
    .rs2_data (bank_rs2)
  );

  always_comb
  begin
    case (instr[6:0])
      op_reg:    opc = op_reg;
      op_imm:    opc = op_imm;
      op_lui:    opc = op_lui;
      op_auipc:  opc = op_auipc;
      op_branch: opc = op_branch;
      op_jal:    opc = op_jal;
      default:   opc = op_illegal;
    endcase

    case (funct3)
      3'b000:  alu_sel = (opc == op_reg && instr[30]) ? alu_sub : alu_add;
      3'b001:  alu_sel = alu_sll;
      3'b010:  alu_sel = alu_slt;
      3'b011:  alu_sel = alu_sltu;
      3'b100:  alu_sel = alu_xor;
      3'b101:  alu_sel = instr[30] ? alu_sra : alu_srl;
      3'b110:  alu_sel = alu_or;
      default: alu_sel = alu_and;
    endcase

    br_ok = 1'b1;
    case (funct3)
      3'b000:  br_sel = alu_eq;
      3'b001:  br_sel = alu_ne;
      3'b100:  br_sel = alu_lt;
      3'b101:  br_sel = alu_ge;
      3'b110:  br_sel = alu_ltu;
      3'b111:  br_sel = alu_geu;
      default:
      begin
        br_sel = alu_eq;
        br_ok  = 1'b0;   // funct3 010/011 is not a branch
      end
    endcase
  end

  always_comb
  begin
    dec_d       = '0;
    dec_d.valid = fetch_in.valid & ~flush;
    dec_d.pc    = fetch_in.pc;
    dec_d.rd    = instr[11:7];
    dec_d.rs1   = instr[19:15];
    dec_d.rs2   = instr[24:20];
    case (opc)
      op_reg:
      begin
        dec_d.alu_op    = alu_sel;
        dec_d.writes_rd = 1'b1;
      end
      op_imm:
      begin
        dec_d.alu_op    = alu_sel;
        dec_d.imm       = imm_i;
        dec_d.b_is_imm  = 1'b1;
        dec_d.writes_rd = 1'b1;
      end
      op_lui, op_auipc:
      begin
        dec_d.alu_op    = (opc == op_lui) ? alu_pass_b : alu_add;
        dec_d.a_is_pc   = (opc == op_auipc);
        dec_d.imm       = imm_u;
        dec_d.b_is_imm  = 1'b1;
        dec_d.writes_rd = 1'b1;
      end
      op_branch:
      begin
        dec_d.alu_op    = br_sel;
        dec_d.imm       = imm_b;
        dec_d.is_branch = br_ok;
      end
      op_jal:
      begin
        dec_d.imm       = imm_j;
        dec_d.is_jal    = 1'b1;
        dec_d.writes_rd = 1'b1;
      end
      default: ;   // illegal passes through as a bubble
    endcase
  end

  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
      dec_valid <= 1'b0;
    else
      dec_valid <= dec_d.valid;
  end

  always_ff @(posedge clk)
  begin
    dec_q    <= dec_d;
    rs1_data <= bank_rs1;
    rs2_data <= bank_rs2;
  end

  always_comb
  begin
    dec_out       = dec_q;
    dec_out.valid = dec_valid;
  end

endmodule

// ==== hw/execute_stage.sv ====
module execute_stage (
  input  logic                    clk,
  input  logic                    rst,
  input  rv_pkg::decoded_t        dec_in,
  input  logic [rv_pkg::xlen-1:0] rs1_data,
  input  logic [rv_pkg::xlen-1:0] rs2_data,
  output rv_pkg::retire_t         wb,
  output rv_pkg::redirect_t       redirect,
  output logic                    busy
);
  import rv_pkg::*;

  logic [xlen-1:0]       fwd_a, fwd_b;
  logic [xlen-1:0]       op_a, op_b;
  logic [xlen-1:0]       pc_word;
  logic [xlen-1:0]       link;
  logic [xlen-1:0]       alu_res;
  logic                  cond;
  logic                  taken;
  logic                  wb_valid;
  logic [reg_addr_w-1:0] wb_rd;
  logic [xlen-1:0]       wb_data;

  assign pc_word = {{(xlen-pc_w){1'b0}}, dec_in.pc};
  assign link    = pc_word + 1'b1;

  // operands were read a cycle ago, so the instruction just ahead
  // is taken from the retire register
  always_comb
  begin
    if (wb.valid && (wb.rd == dec_in.rs1))
      fwd_a = wb.data;
    else
      fwd_a = rs1_data;
    if (wb.valid && (wb.rd == dec_in.rs2))
      fwd_b = wb.data;
    else
      fwd_b = rs2_data;
    op_a = dec_in.a_is_pc ? pc_word : fwd_a;
    op_b = dec_in.b_is_imm ? dec_in.imm : fwd_b;
  end

  always_comb
  begin
    alu_res = '0;
    cond    = 1'b0;
    case (dec_in.alu_op)
      alu_add:    alu_res = op_a + op_b;
      alu_sub:    alu_res = op_a - op_b;
      alu_sll:    alu_res = op_a << op_b[4:0];
      alu_slt:    alu_res = {{(xlen-1){1'b0}}, $signed(op_a) < $signed(op_b)};
      alu_sltu:   alu_res = {{(xlen-1){1'b0}}, op_a < op_b};
      alu_xor:    alu_res = op_a ^ op_b;
      alu_srl:    alu_res = op_a >> op_b[4:0];
      alu_sra:    alu_res = $unsigned($signed(op_a) >>> op_b[4:0]);
      alu_or:     alu_res = op_a | op_b;
      alu_and:    alu_res = op_a & op_b;
      alu_pass_b: alu_res = op_b;
      alu_eq:     cond = (op_a == op_b);
      alu_ne:     cond = (op_a != op_b);
      alu_lt:     cond = $signed(op_a) < $signed(op_b);   // strict less-than
      alu_ge:     cond = $signed(op_a) >= $signed(op_b);
      alu_ltu:    cond = op_a < op_b;
      alu_geu:    cond = op_a >= op_b;
      default:    alu_res = '0;
    endcase
  end

  // fetch predicts not taken, so any taken transfer redirects
  assign taken          = dec_in.is_jal | (dec_in.is_branch & cond);
  assign redirect.valid = dec_in.valid & taken;
  assign redirect.pc    = dec_in.pc + dec_in.imm[pc_w-1:0];

  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
      wb_valid <= 1'b0;
    else
      wb_valid <= dec_in.valid & dec_in.writes_rd & (dec_in.rd != '0);
  end

  always_ff @(posedge clk)
  begin
    wb_rd   <= dec_in.rd;
    wb_data <= dec_in.is_jal ? link : alu_res;   // jal links to pc+1
  end

  assign wb = '{valid: wb_valid, rd: wb_rd, data: wb_data};

  // last record still on its way out counts as work
  assign busy = dec_in.valid | wb_valid;

endmodule

// ==== hw/fetch_unit.sv ====
module fetch_unit (
  input  logic                    clk,
  input  logic                    rst,
  input  logic                    load_valid,
  input  logic [rv_pkg::xlen-1:0] load_word,
  input  logic                    start,
  input  rv_pkg::redirect_t       redirect,
  output rv_pkg::fetch_t          fetch_out,
  output logic                    flush,
  output logic                    drained
);
  import rv_pkg::*;

  logic [xlen-1:0] imem [imem_depth];
  logic [pc_w:0]   prog_len;      // load pointer, becomes the program length
  logic [pc_w-1:0] pc_q;
  fetch_state_e    state;
  logic            fetch_valid;
  logic [pc_w-1:0] fetch_pc;
  logic [xlen-1:0] fetch_instr;
  logic            load_en;
  logic            in_range;
  logic            last_word;
  logic            target_ok;

  assign load_en   = (state == fs_idle) && load_valid && (prog_len < imem_depth);
  assign in_range  = {1'b0, pc_q} < prog_len;
  assign last_word = ({1'b0, pc_q} + 1'b1) >= prog_len;   // also true past the end
  assign target_ok = {1'b0, redirect.pc} < prog_len;

  // decode drops what it holds on a taken branch or jal
  assign flush   = redirect.valid;
  assign drained = (state == fs_drain);

  // load port and registered instruction read
  always_ff @(posedge clk)
  begin
    if (load_en)
      imem[prog_len[pc_w-1:0]] <= load_word;
    fetch_pc    <= pc_q;
    fetch_instr <= imem[pc_q];
  end

  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
    begin
      state       <= fs_idle;
      pc_q        <= '0;
      prog_len    <= '0;
      fetch_valid <= 1'b0;
    end
    else
    begin
      fetch_valid <= 1'b0;
      case (state)
        fs_idle:
        begin
          if (load_en)
            prog_len <= prog_len + 1'b1;
          if (start)
          begin
            state <= fs_run;
            pc_q  <= '0;
          end
        end
        fs_run:
        begin
          if (redirect.valid)
            pc_q <= redirect.pc;   // in-flight read is discarded
          else
          begin
            fetch_valid <= in_range;
            pc_q        <= pc_q + 1'b1;
            if (last_word)
              state <= fs_drain;
          end
        end
        default:
        begin
          // a late branch back into the program restarts fetch
          if (redirect.valid && target_ok)
          begin
            state <= fs_run;
            pc_q  <= redirect.pc;
          end
        end
      endcase
    end
  end

  assign fetch_out = '{valid: fetch_valid, pc: fetch_pc, instr: fetch_instr};

endmodule

// ==== hw/reg_bank.sv ====
module reg_bank (
  input  logic                          clk,
  input  logic                          rst,
  input  logic [rv_pkg::reg_addr_w-1:0] rs1,
  input  logic [rv_pkg::reg_addr_w-1:0] rs2,
  input  rv_pkg::retire_t               wb,
  output logic [rv_pkg::xlen-1:0]       rs1_data,
  output logic [rv_pkg::xlen-1:0]       rs2_data
);
  import rv_pkg::*;

  logic [xlen-1:0] regs [2**reg_addr_w];

  // x0 reads zero, then retire record, then the array
  function automatic logic [xlen-1:0] read_port(input logic [reg_addr_w-1:0] idx);
    logic [xlen-1:0] val;
    if (idx == '0)
      val = '0;
    else if (wb.valid && (wb.rd == idx))
      val = wb.data;   // written this cycle, not yet in the array
    else
      val = regs[idx];
    return val;
  endfunction

  always_comb
  begin
    rs1_data = read_port(rs1);
    rs2_data = read_port(rs2);
  end

  // architectural state starts at zero
  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
    begin
      for (int i = 0; i < 2**reg_addr_w; i++)
        regs[i] <= '0;
    end
    else if (wb.valid && (wb.rd != '0))
    begin
      regs[wb.rd] <= wb.data;
    end
  end

endmodule

// ==== hw/rv32i_core.sv ====
module rv32i_core (
  input  logic                    clk,
  input  logic                    rst,
  input  logic                    load_valid,
  input  logic [rv_pkg::xlen-1:0] load_word,
  input  logic                    start,
  output rv_pkg::retire_t         retire,
  output logic                    done
);
  import rv_pkg::*;

  fetch_t          fetch_bus;
  decoded_t        dec_bus;
  redirect_t       redir;
  logic            flush;
  logic            drained;
  logic            busy;
  logic [xlen-1:0] op1_data, op2_data;

  fetch_unit u_fetch (
    .clk        (clk),
    .rst        (rst),
    .load_valid (load_valid),
    .load_word  (load_word),
    .start      (start),
    .redirect   (redir),
    .fetch_out  (fetch_bus),
    .flush      (flush),
    .drained    (drained)
  );

  decode_stage u_decode (
    .clk      (clk),
    .rst      (rst),
    .fetch_in (fetch_bus),
    .flush    (flush),
    .wb       (retire),     // retire record is also the register write port
    .dec_out  (dec_bus),
    .rs1_data (op1_data),
    .rs2_data (op2_data)
  );

  execute_stage u_execute (
    .clk      (clk),
    .rst      (rst),
    .dec_in   (dec_bus),
    .rs1_data (op1_data),
    .rs2_data (op2_data),
    .wb       (retire),
    .redirect (redir),
    .busy     (busy)
  );

  // no fetch left and nothing in flight
  assign done = drained & ~fetch_bus.valid & ~busy;

endmodule

// ==== hw/rv_pkg.sv ====
package rv_pkg;

  localparam int xlen       = 32;
  localparam int reg_addr_w = 5;
  localparam int imem_depth = 256;
  localparam int pc_w       = 8;   // word index into program memory

  // major opcodes kept by this core
  typedef enum logic [6:0] {
    op_reg     = 7'b0110011,
    op_imm     = 7'b0010011,
    op_lui     = 7'b0110111,
    op_auipc   = 7'b0010111,
    op_branch  = 7'b1100011,
    op_jal     = 7'b1101111,
    op_illegal = 7'b0000000
  } opcode_e;

  typedef enum logic [4:0] {
    alu_add,
    alu_sub,
    alu_sll,
    alu_slt,
    alu_sltu,
    alu_xor,
    alu_srl,
    alu_sra,
    alu_or,
    alu_and,
    alu_pass_b,   // lui
    alu_eq,       // branch compares from here on
    alu_ne,
    alu_lt,
    alu_ge,
    alu_ltu,
    alu_geu
  } alu_op_e;

  typedef enum logic [1:0] {
    fs_idle,
    fs_run,
    fs_drain
  } fetch_state_e;

  typedef struct packed {
    logic            valid;
    logic [pc_w-1:0] pc;
    logic [xlen-1:0] instr;
  } fetch_t;

  // ID/EX register contents
  typedef struct packed {
    logic                  valid;
    logic [pc_w-1:0]       pc;
    logic [reg_addr_w-1:0] rd;
    logic [reg_addr_w-1:0] rs1;
    logic [reg_addr_w-1:0] rs2;
    logic [xlen-1:0]       imm;
    alu_op_e               alu_op;
    logic                  b_is_imm;
    logic                  a_is_pc;
    logic                  is_branch;
    logic                  is_jal;
    logic                  writes_rd;
  } decoded_t;

  typedef struct packed {
    logic            valid;
    logic [pc_w-1:0] pc;
  } redirect_t;

  typedef struct packed {
    logic                  valid;
    logic [reg_addr_w-1:0] rd;
    logic [xlen-1:0]       data;
  } retire_t;

endpackage

// ==== sim/core_checker.sv ====
module core_checker (
  input logic            clk,
  input logic            rst,
  input logic            start,
  input rv_pkg::retire_t retire,
  input logic            done
);
  timeunit 1ns;
  timeprecision 100ps;

  quiet_in_reset: assert property (@(posedge clk) rst |-> !retire.valid && !done)
    else $error("retire valid or done high while in reset");

  // done holds until a new run is started
  done_sticky: assert property (@(posedge clk) disable iff (rst) done && !start |=> done)
    else $error("done fell without a start");

  idle_after_done: assert property (@(posedge clk) disable iff (rst) done |-> !retire.valid)
    else $error("retire record while done is high");

  no_x0_retire: assert property (@(posedge clk) disable iff (rst)
                                 retire.valid |-> retire.rd != '0)
    else $error("retire record targets x0");

endmodule

bind rv32i_core core_checker u_checker (
  .clk    (clk),
  .rst    (rst),
  .start  (start),
  .retire (retire),
  .done   (done)
);

// ==== sim/core_tb.sv ====
module core_tb;
  timeunit 1ns;
  timeprecision 100ps;
  import rv_pkg::*;

  localparam int prog_len     = 40;
  localparam int n_programs   = 16;
  localparam int done_timeout = 2000;

  logic            clk;
  logic            rst;
  logic            load_valid;
  logic [xlen-1:0] load_word;
  logic            start;
  retire_t         retire;
  logic            done;

  logic [31:0] lfsr_state;
  logic [31:0] prog [prog_len];
  retire_t     exp_q [$];
  retire_t     exp_rec;

  rv32i_core dut0 (
    .clk        (clk),
    .rst        (rst),
    .load_valid (load_valid),
    .load_word  (load_word),
    .start      (start),
    .retire     (retire),
    .done       (done)
  );

  always #50 clk = ~clk;

  // galois form, taps 32 22 2 1
  function automatic logic lfsr_bit();
    logic out;
    out = lfsr_state[0];
    lfsr_state = lfsr_state >> 1;
    if (out)
      lfsr_state = lfsr_state ^ 32'h8020_0003;
    return out;
  endfunction

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] val;
    val = '0;
    for (int i = 0; i < n; i++)
      val = {val[30:0], lfsr_bit()};
    return val;
  endfunction

  function automatic logic [31:0] gen_instr();
    logic [2:0]  kind;
    logic [2:0]  f3;
    logic [4:0]  rd;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic [19:0] upper;
    logic [11:0] imm;
    logic [3:0]  ofs;
    logic        alt;
    logic [31:0] w;
    kind  = rand_bits(3);
    f3    = rand_bits(3);
    rd    = rand_bits(3);   // x0..x7 only, so chains form often
    rs1   = rand_bits(3);
    rs2   = rand_bits(3);
    upper = rand_bits(20);
    imm   = upper[11:0];
    alt   = rand_bits(1);
    ofs   = 4'd1 + 4'(rand_bits(3) % 6);   // forward 1..6 words
    case (kind)
      3'd0, 3'd1:
        w = {1'b0, alt && (f3 == 3'd0 || f3 == 3'd5), 5'b0, rs2, rs1, f3, rd, 7'b0110011};
      3'd2, 3'd3:
      begin
        if (f3 == 3'd1 || f3 == 3'd5)
          imm = {1'b0, alt && (f3 == 3'd5), 5'b0, imm[4:0]};   // shamt form
        w = {imm, rs1, f3, rd, 7'b0010011};
      end
      3'd4:
        w = {upper, rd, 7'b0110111};
      3'd5:
        w = {upper, rd, 7'b0010111};
      3'd6:
      begin
        if (f3 == 3'd2 || f3 == 3'd3)
          f3 = f3 + 3'd2;   // 010 and 011 are not branches
        w = {7'b0, rs2, rs1, f3, ofs, 1'b0, 7'b1100011};
      end
      default:
        w = {1'b0, 6'b0, ofs, 1'b0, 8'b0, rd, 7'b1101111};
    endcase
    return w;
  endfunction

  function automatic logic [31:0] alu_model(input logic [2:0] f3, input logic alt,
                                            input logic [31:0] a, input logic [31:0] b);
    logic [31:0] r;
    case (f3)
      3'd0: r = alt ? a - b : a + b;
      3'd1: r = a << b[4:0];
      3'd2: r = {31'b0, $signed(a) < $signed(b)};
      3'd3: r = {31'b0, a < b};
      3'd4: r = a ^ b;
      3'd5:
      begin
        if (alt)
          r = $signed(a) >>> b[4:0];
        else
          r = a >> b[4:0];
      end
      3'd6: r = a | b;
      default: r = a & b;
    endcase
    return r;
  endfunction

  function automatic logic branch_model(input logic [2:0] f3, input logic [31:0] a,
                                        input logic [31:0] b);
    case (f3)
      3'd0: return a == b;
      3'd1: return a != b;
      3'd4: return $signed(a) < $signed(b);
      3'd5: return $signed(a) >= $signed(b);
      3'd6: return a < b;
      default: return a >= b;
    endcase
  endfunction

  // runs the program on word pcs and queues every register write
  task automatic build_expected();
    logic [31:0] regs [32];
    logic [31:0] ins;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] res;
    logic [31:0] step;
    logic [2:0]  f3;
    logic        wr;
    int          pc;
    for (int i = 0; i < 32; i++)
      regs[i] = '0;
    pc = 0;
    while (pc < prog_len)
    begin
      ins  = prog[pc];
      f3   = ins[14:12];
      a    = regs[ins[19:15]];
      b    = regs[ins[24:20]];
      wr   = 1'b1;
      res  = '0;
      step = 32'd1;
      case (ins[6:0])
        7'b0110011: res = alu_model(f3, ins[30], a, b);
        7'b0010011: res = alu_model(f3, ins[30] && f3 == 3'd5, a, {{20{ins[31]}}, ins[31:20]});
        7'b0110111: res = {ins[31:12], 12'h0};
        7'b0010111: res = pc + {ins[31:12], 12'h0};
        7'b1101111:
        begin
          res  = pc + 1;   // link is the next word
          step = {{12{ins[31]}}, ins[31], ins[19:12], ins[20], ins[30:21]};
        end
        default:
        begin
          wr = 1'b0;
          if (branch_model(f3, a, b))
            step = {{20{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8]};
        end
      endcase
      if (wr && ins[11:7] != 5'd0)
      begin
        regs[ins[11:7]] = res;
        exp_q.push_back('{valid: 1'b1, rd: ins[11:7], data: res});
      end
      pc = pc + int'(step);
    end
  endtask

  task automatic stop_with_failure();
    $display("TB FAILED");
    $fatal(1, "simulation stopped on first error");
  endtask

  task automatic check_value(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
    if (actual !== expected)
    begin
      $display("ERROR %0t ns %s: got 0x%08h, expected 0x%08h", $time, name, actual, expected);
      stop_with_failure();
    end
  endtask

  task automatic apply_reset();
    @(negedge clk);
    rst = 1'b1;
    repeat (16) @(negedge clk);
    rst = 1'b0;
  endtask

  task automatic load_and_start();
    for (int i = 0; i < prog_len; i++)
    begin
      @(negedge clk);
      load_valid = 1'b1;
      load_word  = prog[i];
    end
    @(negedge clk);
    load_valid = 1'b0;
    start      = 1'b1;
    @(negedge clk);
    start = 1'b0;
  endtask

  task automatic wait_for_done();
    int cycles;
    cycles = 0;
    while (!done)
    begin
      @(negedge clk);
      cycles++;
      if (cycles > done_timeout)
      begin
        $display("done did not rise within %0d cycles after start", done_timeout);
        stop_with_failure();
      end
    end
  endtask

  // retire changes on the rising edge, look at it half a cycle later
  always @(negedge clk)
  begin
    if (!rst && retire.valid)
    begin
      if (exp_q.size() == 0)
      begin
        $display("retire for x%0d at %0t ns with nothing left to retire", retire.rd, $time);
        stop_with_failure();
      end
      else
      begin
        exp_rec = exp_q.pop_front();
        check_value("retire.rd", 32'(retire.rd), 32'(exp_rec.rd));
        check_value("retire.data", retire.data, exp_rec.data);
      end
    end
  end

  initial
  begin
    clk        = 1'b0;
    rst        = 1'b1;
    load_valid = 1'b0;
    load_word  = '0;
    start      = 1'b0;
    lfsr_state = 32'd15;
    for (int p = 0; p < n_programs; p++)
    begin
      for (int i = 0; i < prog_len; i++)
        prog[i] = gen_instr();
      build_expected();
      apply_reset();
      load_and_start();
      wait_for_done();
      if (exp_q.size() != 0)
      begin
        $display("program %0d: %0d retire records still missing at done", p, exp_q.size());
        stop_with_failure();
      end
    end
    $display("TB PASSED");
    $finish;
  end

endmodule

// ==== src.f ====
hw/rv_pkg.sv
hw/fetch_unit.sv
hw/reg_bank.sv
hw/decode_stage.sv
hw/execute_stage.sv
hw/rv32i_core.sv
sim/core_checker.sv
sim/core_tb.sv
